// File: arithUnit.f
hdl/aluPkg.sv
hdl/inputSync.sv
hdl/opSequencer.sv
hdl/modeRegs.sv
hdl/arithDatapath.sv
hdl/arithUnit.sv
testbench/arithUnitTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the arithUnit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f arithUnit.f --top-module arithUnitTb -o arithUnitSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/arithUnitSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

// File: testbench/arithUnitTb.sv
// Table-driven testbench for arithUnit; runs each row against a reference model and checks results
module arithUnitTb;
  import aluPkg::*;

  localparam int Period    = 20;
  localparam int DriveDly  = 2;
  localparam int DoneLimit = 20;
  // Flag bit order is overflow, negative, done, error
  localparam logic [3:0] LoadMask = 4'b0011;
  localparam logic [3:0] OpMask   = 4'b1111;

  typedef struct packed {
    opT         op;
    logic       regSel;
    logic       hiByte;
    logic       write;
    logic       signedMode;
    byteT       data;
    logic [3:0] mask;
    int         hold;
    logic       toggle;
  } rowT;

  logic   CLK;
  logic   RST;
  ctrlT   ctrl;
  byteT   dataIn;
  byteT   dataOut;
  flagsT  flags;
  rowT    rows[$];
  integer seed;
  int     cycleCount = 0;
  int     cycleLimit;
  int     rowErrors;
  int     passCount = 0;
  int     failCount = 0;

  // Reference model state
  wordT       refA;
  wordT       refB;
  logic       refOvf;
  logic       refNeg;
  logic       refErr;
  logic [1:0] refSel;

  arithUnit #(
    .MulSteps (MulSteps)
  ) i_dut (
    .CLK     (CLK),
    .RST     (RST),
    .ctrl    (ctrl),
    .dataIn  (dataIn),
    .dataOut (dataOut),
    .flags   (flags)
  );

  initial
  begin
    CLK = 1'b0;
    forever #(Period / 2) CLK = ~CLK;
  end

  // Watchdog
  always @(posedge CLK)
  begin
    cycleCount++;
    if (cycleCount >= cycleLimit)
    begin
      $display("Run stopped after %0d cycles without finishing", cycleLimit);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Table construction
  task automatic addRow(input opT op, input logic regSel, input logic hiByte,
                        input logic write, input logic signedMode, input byteT data,
                        input logic [3:0] mask, input int hold, input logic toggle);
    rowT r;
    r.op         = op;
    r.regSel     = regSel;
    r.hiByte     = hiByte;
    r.write      = write;
    r.signedMode = signedMode;
    r.data       = data;
    r.mask       = mask;
    r.hold       = hold;
    r.toggle     = toggle;
    rows.push_back(r);
  endtask

  task automatic loadWord(input logic regSel, input wordT w);
    addRow(opLoad, regSel, 1'b0, 1'b1, 1'b0, w[7:0], LoadMask, 0, 1'b0);
    addRow(opLoad, regSel, 1'b1, 1'b1, 1'b0, w[15:8], LoadMask, 0, 1'b0);
  endtask

  task automatic readBack(input logic regSel);
    addRow(opLoad, regSel, 1'b0, 1'b0, 1'b0, 8'h00, LoadMask, 0, 1'b0);
    addRow(opLoad, regSel, 1'b1, 1'b0, 1'b0, 8'h00, LoadMask, 0, 1'b0);
  endtask

  task automatic opRow(input opT op, input logic sgn, input byteT data, input int hold,
                       input logic toggle);
    addRow(op, 1'b0, 1'b0, 1'b0, sgn, data, OpMask, hold, toggle);
  endtask

  task automatic buildTable();
    wordT w;
    byteT m;
    // Plain loads and read-back
    loadWord(1'b0, 16'h1234);
    loadWord(1'b1, 16'h5678);
    readBack(1'b0);
    readBack(1'b1);
    // Unsigned carry, borrow, then no borrow
    loadWord(1'b1, 16'hfff0);
    loadWord(1'b0, 16'h0020);
    opRow(opAdd, 1'b0, 8'h00, 0, 1'b0);
    readBack(1'b1);
    opRow(opSub, 1'b0, 8'h00, 0, 1'b0);
    readBack(1'b1);
    opRow(opSub, 1'b0, 8'h00, 0, 1'b0);
    readBack(1'b1);
    // Signed mode with random operands
    repeat (4)
    begin
      w = 16'($random(seed));
      loadWord(1'b0, w);
      w = 16'($random(seed));
      loadWord(1'b1, w);
      opRow(opAdd, 1'b1, 8'h00, 0, 1'b0);
      readBack(1'b1);
      opRow(opSub, 1'b1, 8'h00, 0, 1'b0);
      readBack(1'b1);
    end
    // Multiply with random multiplier
    repeat (3)
    begin
      w = 16'($random(seed));
      loadWord(1'b0, w);
      w = 16'($random(seed));
      loadWord(1'b1, w);
      m = 8'($random(seed));
      opRow(opMul, 1'b0, m, 0, 1'b0);
      readBack(1'b0);
      readBack(1'b1);
    end
    // Held start runs once
    opRow(opAdd, 1'b0, 8'h00, 5, 1'b0);
    readBack(1'b1);
    // Signed mode flipped under a held start sets the sticky error
    opRow(opAdd, 1'b0, 8'h00, 0, 1'b1);
    opRow(opSub, 1'b0, 8'h00, 0, 1'b0);
    readBack(1'b1);
  endtask

  //////////////////////////////
  // Reference model
  task automatic applyModel(input rowT r);
    logic [16:0] full;
    wordT        res;
    logic        carry;
    byteT        mulBits;
    if (r.toggle)
      refErr = 1'b1;
    case (r.op)
      opLoad:
      begin
        if (!r.write)
          refSel = {r.regSel, r.hiByte};
        else if (r.regSel && r.hiByte)
          refB[15:8] = r.data;
        else if (r.regSel)
          refB[7:0] = r.data;
        else if (r.hiByte)
          refA[15:8] = r.data;
        else
          refA[7:0] = r.data;
      end
      opAdd:
      begin
        full   = {1'b0, refB} + {1'b0, refA};
        res    = full[15:0];
        refOvf = r.signedMode ? ((refA[15] == refB[15]) && (res[15] != refB[15])) : full[16];
        refNeg = r.signedMode ? res[15] : 1'b0;
        refB   = res;
      end
      opSub:
      begin
        res    = refB - refA;
        carry  = (refA > refB);
        refOvf = r.signedMode ? ((refA[15] != refB[15]) && (res[15] != refB[15])) : carry;
        refNeg = r.signedMode ? res[15] : carry;
        refB   = res;
      end
      default:
      begin
        // Shift-and-add from the lowest multiplier bit
        carry   = 1'b0;
        mulBits = r.data;
        repeat (MulSteps)
        begin
          if (mulBits[0])
          begin
            full  = {1'b0, refB} + {1'b0, refA};
            carry = carry | full[16];
            refB  = full[15:0];
          end
          refA    = refA << 1;
          mulBits = mulBits >> 1;
        end
        refOvf = carry;
        refNeg = 1'b0;
      end
    endcase
  endtask

  function automatic byteT expectedByte();
    case (refSel)
      2'b00:   return refA[7:0];
      2'b01:   return refA[15:8];
      2'b10:   return refB[7:0];
      default: return refB[15:8];
    endcase
  endfunction

  //////////////////////////////
  // Checks and row execution
  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
      rowErrors++;
    end
  endtask

  task automatic reportTest(input string name);
    if (rowErrors == 0)
    begin
      passCount++;
      $display("%s: ok", name);
    end
    else
    begin
      failCount++;
      $display("%s: %0d check(s) failed", name, rowErrors);
    end
  endtask

  task automatic driveRow(input rowT r);
    ctrl.start      = 1'b1;
    ctrl.op         = r.op;
    ctrl.regSel     = r.regSel;
    ctrl.hiByte     = r.hiByte;
    ctrl.write      = r.write;
    ctrl.signedMode = r.signedMode;
    dataIn          = r.data;
  endtask

  task automatic runRow(input int idx, input rowT r);
    int   waited;
    int   expLatency;
    logic seen;
    opT   op;
    op         = r.op;
    rowErrors  = 0;
    expLatency = (r.op == opMul) ? MulSteps + 3 : 3;
    @(posedge CLK);
    #DriveDly;
    driveRow(r);
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < DoneLimit)
    begin
      @(posedge CLK);
      waited++;
      @(negedge CLK);
      seen = flags.done;
    end
    assert (seen)
    else
    begin
      $display("row %0d: done did not rise within %0d cycles", idx, DoneLimit);
      rowErrors++;
    end
    applyModel(r);
    if (seen)
    begin
      checkValue("doneLatency", waited, expLatency);
      repeat (r.hold) @(posedge CLK);
      if (r.toggle)
      begin
        @(posedge CLK);
        #DriveDly;
        ctrl.signedMode = ~ctrl.signedMode;
        repeat (2) @(posedge CLK);
      end
      @(negedge CLK);
      checkValue("dataOut", 32'(dataOut), 32'(expectedByte()));
      checkValue("flags", 32'(flags & r.mask), 32'({refOvf, refNeg, 1'b1, refErr} & r.mask));
    end
    @(posedge CLK);
    #DriveDly;
    ctrl.start = 1'b0;
    // One input-register edge, then the sequencer passes through waitLow before done drops
    waited = 0;
    seen   = 1'b1;
    while (seen && waited < DoneLimit)
    begin
      @(posedge CLK);
      waited++;
      @(negedge CLK);
      seen = flags.done;
    end
    assert (!seen)
    else
    begin
      $display("row %0d: done stayed high after start dropped", idx);
      rowErrors++;
    end
    checkValue("doneFall", waited, 3);
    reportTest($sformatf("row %0d %s", idx, op.name()));
  endtask

  task automatic applyReset();
    @(posedge CLK);
    #DriveDly;
    RST = 1'b1;
    repeat (3) @(posedge CLK);
    #DriveDly;
    RST    = 1'b0;
    refA   = '0;
    refB   = '0;
    refOvf = 1'b0;
    refNeg = 1'b0;
    refErr = 1'b0;
    refSel = '0;
  endtask

  task automatic checkResetState(input string name);
    rowErrors = 0;
    @(negedge CLK);
    checkValue("dataOut", 32'(dataOut), 32'h0);
    checkValue("flags", 32'(flags), 32'h0);
    reportTest(name);
  endtask

  //////////////////////////////
  // Main sequence
  initial
  begin
    RST    = 1'b1;
    ctrl   = '0;
    dataIn = '0;
    seed   = 32'h82b9_699d;
    buildTable();
    cycleLimit = rows.size() * 30 + 50;
    applyReset();
    checkResetState("reset");
    foreach (rows[i])
      runRow(i, rows[i]);
    applyReset();
    checkResetState("second reset clears error");
    $display("tests passed %0d failed %0d", passCount, failCount);
    if (failCount == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: hdl/arithUnit.sv
// Top level of the byte-bus arithmetic unit; connects input stage, sequencer, mode registers, datapath
module arithUnit #(
  parameter int MulSteps = aluPkg::MulSteps
) (
  input  logic          CLK,
  input  logic          RST,
  input  aluPkg::ctrlT  ctrl,
  input  aluPkg::byteT  dataIn,
  output aluPkg::byteT  dataOut,
  output aluPkg::flagsT flags
);
  import aluPkg::*;

  ctrlT     syncCtrl;
  byteT     syncData;
  logic     syncError;
  logic     execute;
  logic     stepEn;
  stepT     stepIdx;
  logic     seqDone;
  readSelT  readSel;
  logic     opSigned;
  logic     overflow;
  logic     negative;

  inputSync i_inputSync (
    .CLK      (CLK),
    .RST      (RST),
    .ctrl     (ctrl),
    .dataIn   (dataIn),
    .syncCtrl (syncCtrl),
    .syncData (syncData),
    .error    (syncError)
  );

  opSequencer #(
    .MulSteps (MulSteps)
  ) i_opSequencer (
    .CLK     (CLK),
    .RST     (RST),
    .start   (syncCtrl.start),
    .op      (syncCtrl.op),
    .execute (execute),
    .stepEn  (stepEn),
    .stepIdx (stepIdx),
    .busy    (),
    .done    (seqDone)
  );

  modeRegs i_modeRegs (
    .CLK      (CLK),
    .RST      (RST),
    .execute  (execute),
    .ctrl     (syncCtrl),
    .readSel  (readSel),
    .opSigned (opSigned)
  );

  arithDatapath #(
    .MulSteps (MulSteps)
  ) i_arithDatapath (
    .CLK      (CLK),
    .RST      (RST),
    .execute  (execute),
    .stepEn   (stepEn),
    .stepIdx  (stepIdx),
    .op       (syncCtrl.op),
    .write    (syncCtrl.write),
    .regSel   (syncCtrl.regSel),
    .hiByte   (syncCtrl.hiByte),
    .data     (syncData),
    .readSel  (readSel),
    .opSigned (opSigned),
    .dataOut  (dataOut),
    .overflow (overflow),
    .negative (negative)
  );

  assign flags.overflow = overflow;
  assign flags.negative = negative;
  assign flags.done     = seqDone;
  assign flags.error    = syncError;

endmodule

// File: hdl/arithDatapath.sv
// Arithmetic datapath; A/B registers, shared adder for add, subtract and multiply, flags and output
module arithDatapath #(
  parameter int MulSteps = aluPkg::MulSteps
) (
  input  logic             CLK,
  input  logic             RST,
  input  logic             execute,
  input  logic             stepEn,
  input  aluPkg::stepT     stepIdx,
  input  aluPkg::opT       op,
  input  logic             write,
  input  logic             regSel,
  input  logic             hiByte,
  input  aluPkg::byteT     data,
  input  aluPkg::readSelT  readSel,
  input  logic             opSigned,
  output aluPkg::byteT     dataOut,
  output logic             overflow,
  output logic             negative
);
  import aluPkg::*;

  // Bits needed to pick one multiplier bit per step
  localparam int IdxW = $clog2(MulSteps);

  wordT           aReg;
  wordT           bReg;
  byteT           mulByte;
  opT             lastOp;
  logic           carryFlag;
  logic           ovfFlag;
  logic           msbFlag;
  byteT           mulSrc;
  logic           mulBit;
  logic           isSub;
  logic           carryIn;
  wordT           addend;
  logic [WordW:0] sum;
  logic           sumOvf;

  //////////////////////////////
  // Shared adder
  assign isSub   = (op == opSub);
  assign carryIn = isSub && !stepEn;

  // Multiplier byte is not registered yet during step 0
  assign mulSrc = execute ? data : mulByte;
  assign mulBit = mulSrc[stepIdx[IdxW-1:0]];

  always_comb
  begin
    if (stepEn)
      addend = mulBit ? aReg : '0;
    else if (isSub)
      addend = ~aReg;
    else
      addend = aReg;
  end

  assign sum    = {1'b0, bReg} + {1'b0, addend} + {{WordW{1'b0}}, carryIn};
  assign sumOvf = (bReg[WordW-1] == addend[WordW-1]) && (sum[WordW-1] != bReg[WordW-1]);

  //////////////////////////////
  // Registers
  always_ff @(posedge CLK)
  begin
    if (RST)
    begin
      aReg      <= '0;
      bReg      <= '0;
      lastOp    <= opLoad;
      carryFlag <= 1'b0;
      ovfFlag   <= 1'b0;
      msbFlag   <= 1'b0;
    end
    else
    begin
      // Byte load, other byte untouched
      if (execute && (op == opLoad) && write)
      begin
        if (regSel && hiByte)
          bReg[WordW-1:ByteW] <= data;
        else if (regSel)
          bReg[ByteW-1:0] <= data;
        else if (hiByte)
          aReg[WordW-1:ByteW] <= data;
        else
          aReg[ByteW-1:0] <= data;
      end
      if (execute && (op != opLoad))
      begin
        lastOp    <= op;
        carryFlag <= 1'b0;
        ovfFlag   <= 1'b0;
        msbFlag   <= 1'b0;
      end
      if (execute && ((op == opAdd) || (op == opSub)))
      begin
        bReg      <= sum[WordW-1:0];
        // Borrow is the inverted carry out
        carryFlag <= isSub ? ~sum[WordW] : sum[WordW];
        ovfFlag   <= sumOvf;
        msbFlag   <= sum[WordW-1];
      end
      // One multiply step, accumulate then shift A
      if (stepEn)
      begin
        if (mulBit)
          bReg <= sum[WordW-1:0];
        aReg      <= aReg << 1;
        carryFlag <= (carryFlag && !execute) || (mulBit && sum[WordW]);
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (execute)
      mulByte <= data;
  end

  //////////////////////////////
  // Flags, mode picks which raw flag is shown
  assign overflow = (opSigned && (lastOp != opMul)) ? ovfFlag : carryFlag;

  always_comb
  begin
    if (lastOp == opMul)
      negative = 1'b0;
    else if (opSigned)
      negative = msbFlag;
    else
      negative = (lastOp == opSub) && carryFlag;
  end

  // Output byte
  always_comb
  begin
    case ({readSel.regSel, readSel.hiByte})
      2'b00:   dataOut = aReg[ByteW-1:0];
      2'b01:   dataOut = aReg[WordW-1:ByteW];
      2'b10:   dataOut = bReg[ByteW-1:0];
      default: dataOut = bReg[WordW-1:ByteW];
    endcase
  end

endmodule

// File: hdl/modeRegs.sv
// Mode registers beside the sequencer; hold the read selection and the signed mode of an operation
module modeRegs (
  input  logic             CLK,
  input  logic             RST,
  input  logic             execute,
  input  aluPkg::ctrlT     ctrl,
  output aluPkg::readSelT  readSel,
  output logic             opSigned
);
  import aluPkg::*;

  logic readReq;

  // Load with write low only moves the output window
  assign readReq = execute && (ctrl.op == opLoad) && !ctrl.write;

  //////////////////////////////
  // Read selection
  always_ff @(posedge CLK)
  begin
    if (RST)
      readSel <= '0;
    else if (readReq)
    begin
      readSel.regSel <= ctrl.regSel;
      readSel.hiByte <= ctrl.hiByte;
    end
  end

  //////////////////////////////
  // Signed mode, taken once per operation
  always_ff @(posedge CLK)
  begin
    if (RST)
      opSigned <= 1'b0;
    else if (execute)
      opSigned <= ctrl.signedMode;
  end

endmodule

// File: hdl/opSequencer.sv
// Operation sequencer; turns a held start level into one execute pulse, multiply steps and done
module opSequencer #(
  parameter int MulSteps = aluPkg::MulSteps
) (
  input  logic         CLK,
  input  logic         RST,
  input  logic         start,
  input  aluPkg::opT   op,
  output logic         execute,
  output logic         stepEn,
  output aluPkg::stepT stepIdx,
  output logic         busy,
  output logic         done
);
  import aluPkg::*;

  typedef enum logic [2:0] {
    idle,
    exec,
    mulStep,
    finished,
    waitLow
  } seqStateT;

  seqStateT state;
  seqStateT nextState;

  //////////////////////////////
  // Next state
  always_comb
  begin
    nextState = state;
    case (state)
      idle:
        if (start)
          nextState = exec;
      exec:
        if (op == opMul)
          nextState = mulStep;
        else
          nextState = finished;
      // Counter reaching MulSteps is one spare cycle after the last step
      mulStep:
        if (stepIdx == stepT'(MulSteps))
          nextState = finished;
      // Hold done until start drops
      finished:
        if (!start)
          nextState = waitLow;
      waitLow:
        nextState = idle;
      default:
        nextState = idle;
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (RST)
      state <= idle;
    else
      state <= nextState;
  end

  //////////////////////////////
  // Step counter
  always_ff @(posedge CLK)
  begin
    if (RST)
      stepIdx <= '0;
    else if (stepEn)
      stepIdx <= stepIdx + 1'b1;
    else if (state == idle)
      stepIdx <= '0;
  end

  // Step 0 runs in the execute cycle itself
  assign stepEn = ((state == exec) && (op == opMul)) ||
                  ((state == mulStep) && (stepIdx != stepT'(MulSteps)));

  assign execute = (state == exec);
  assign busy    = (state == exec) || (state == mulStep);
  assign done    = (state == finished) || (state == waitLow);

endmodule

// File: hdl/inputSync.sv
// Input register stage; samples the bus byte and control word and flags signed-mode changes
module inputSync (
  input  logic          CLK,
  input  logic          RST,
  input  aluPkg::ctrlT  ctrl,
  input  aluPkg::byteT  dataIn,
  output aluPkg::ctrlT  syncCtrl,
  output aluPkg::byteT  syncData,
  output logic          error
);

  // Previous synchronized sample
  logic prevStart;
  logic prevSigned;

  always_ff @(posedge CLK)
  begin
    if (RST)
    begin
      syncCtrl   <= '0;
      prevStart  <= 1'b0;
      prevSigned <= 1'b0;
      error      <= 1'b0;
    end
    else
    begin
      syncCtrl   <= ctrl;
      prevStart  <= syncCtrl.start;
      prevSigned <= syncCtrl.signedMode;
      // Sticky until reset
      if (syncCtrl.start && prevStart && (syncCtrl.signedMode != prevSigned))
        error <= 1'b1;
    end
  end

  // Data byte, only consumed on execute or multiply capture
  always_ff @(posedge CLK)
  begin
    syncData <= dataIn;
  end

endmodule

// File: hdl/aluPkg.sv
// Shared widths, vector types, operation codes and control/status structs for the arithmetic unit
package aluPkg;

  // Bus and register widths
  localparam int ByteW = 8;
  localparam int WordW = 16;

  // Shift-and-add steps for one multiply
  localparam int MulSteps = 8;

  typedef logic [ByteW-1:0] byteT;
  typedef logic [WordW-1:0] wordT;

  // Multiply step counter, wide enough to hold MulSteps itself
  typedef logic [3:0] stepT;

  typedef enum logic [1:0] {
    opLoad,
    opAdd,
    opSub,
    opMul
  } opT;

  // Control word from the bus, sampled every cycle
  typedef struct packed {
    logic start;
    opT   op;
    logic regSel;      // 0 = A, 1 = B
    logic hiByte;      // 0 = low byte, 1 = high byte
    logic write;       // 1 = load, 0 = latch read selection
    logic signedMode;
  } ctrlT;

  typedef struct packed {
    logic overflow;
    logic negative;
    logic done;
    logic error;
  } flagsT;

  // Byte shown on the output
  typedef struct packed {
    logic regSel;
    logic hiByte;
  } readSelT;

endpackage
